// ==== verilog/ps2_pkg.sv ====
// Shared PS/2 receiver constants, imported by the receiver, queue, decoder and testbench
package ps2_pkg;

    // Frame layout
    // Start bit, eight data bits LSB first, odd parity, stop bit
    localparam int PS2_DATA_BITS = 8;

    // Data plus parity, the bits held in the receiver's shift register
    localparam int PS2_SHIFT_BITS = PS2_DATA_BITS + 1;

    // Silence timeout
    // Counted in peripheral_clock rising edges since the last device clock edge
    localparam logic [15:0] PS2_TIMEOUT_TICKS = 16'd1000;

    // Scancode byte queue
    localparam int PS2_FIFO_DEPTH = 8;
    localparam int PS2_FIFO_ADDR_BITS = $clog2(PS2_FIFO_DEPTH);

    // Scancode set 2 prefixes
    // E0 marks an extended key, F0 marks a key release
    localparam logic [PS2_DATA_BITS-1:0] PS2_PREFIX_EXTENDED = 8'hE0;
    localparam logic [PS2_DATA_BITS-1:0] PS2_PREFIX_RELEASE = 8'hF0;

endpackage

// ==== verilog/ps2_shift_register.sv ====
// PS/2 frame receiver; shifts in device frames and strobes out good bytes or an error pulse
`timescale 1ns/10ps

module ps2_shift_register (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               peripheral_clock,
    input  logic                               device_clock,
    input  logic                               device_data,
    output logic [ps2_pkg::PS2_DATA_BITS-1:0]  byte_data,
    output logic                               byte_strobe,
    output logic                               frame_error
);
    import ps2_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RECEIVING,
        STOP_BIT
    } state_t;

    state_t                       state;
    state_t                       next_state;

    logic                         peripheral_clock_d1;
    logic                         peripheral_clock_d2;
    logic                         tick;

    logic                         prev_device_clock;
    logic                         device_clock_fall;
    logic                         device_clock_toggle;

    logic [PS2_SHIFT_BITS-1:0]    shift_register;
    logic [3:0]                   bit_count;
    logic [15:0]                  silence_ticks;
    logic                         timeout;
    logic                         frame_ok;
    logic                         stop_edge;

    // Rising edge of the slow timebase
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            peripheral_clock_d1 <= 1'b0;
            peripheral_clock_d2 <= 1'b0;
        end else begin
            peripheral_clock_d1 <= peripheral_clock;
            peripheral_clock_d2 <= peripheral_clock_d1;
        end
    end

    assign tick = peripheral_clock_d1 & ~peripheral_clock_d2;

    // Line idles high, so start from high to avoid a false edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prev_device_clock <= 1'b1;
        end else begin
            prev_device_clock <= device_clock;
        end
    end

    assign device_clock_fall   = prev_device_clock & ~device_clock;
    assign device_clock_toggle = prev_device_clock ^ device_clock;

    // Data and parity arrive LSB first
    always_ff @(posedge clock) begin
        if (state == RECEIVING && device_clock_fall) begin
            shift_register <= {device_data, shift_register[PS2_SHIFT_BITS-1:1]};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bit_count <= 4'd0;
        end else if (state == IDLE) begin
            bit_count <= 4'd0;
        end else if (state == RECEIVING && device_clock_fall) begin
            bit_count <= bit_count + 4'd1;
        end
    end

    // Silence counter, restarted by any activity on the device clock
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            silence_ticks <= 16'd0;
        end else if (state == IDLE || device_clock_toggle || timeout) begin
            silence_ticks <= 16'd0;
        end else if (tick) begin
            silence_ticks <= silence_ticks + 16'd1;
        end
    end

    assign timeout = (silence_ticks >= PS2_TIMEOUT_TICKS);

    // Odd parity over data and parity bit, and a high stop bit
    assign frame_ok  = device_data & (^shift_register);
    assign stop_edge = (state == STOP_BIT) && device_clock_fall;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            byte_strobe <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            frame_error <= 1'b0;
            if (timeout) begin
                frame_error <= 1'b1;
            end else if (stop_edge) begin
                if (frame_ok) begin
                    byte_strobe <= 1'b1;
                end else begin
                    frame_error <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (stop_edge && frame_ok && !timeout) begin
            byte_data <= shift_register[PS2_DATA_BITS-1:0];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Start bit is a low data line on the first falling edge
                if (device_clock_fall && !device_data) begin
                    next_state = RECEIVING;
                end
            end
            RECEIVING: begin
                if (device_clock_fall && bit_count == 4'(PS2_SHIFT_BITS - 1)) begin
                    next_state = STOP_BIT;
                end
            end
            STOP_BIT: begin
                if (device_clock_fall) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
        if (timeout) begin
            next_state = IDLE;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== verilog/ps2_fifo.sv ====
// Show-ahead scancode byte queue between the frame receiver and the decoder
`timescale 1ns/10ps

module ps2_fifo (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               push,
    input  logic [ps2_pkg::PS2_DATA_BITS-1:0]  push_data,
    input  logic                               pop,
    output logic [ps2_pkg::PS2_DATA_BITS-1:0]  pop_data,
    output logic                               empty
);
    import ps2_pkg::*;

    logic [PS2_DATA_BITS-1:0]       mem [PS2_FIFO_DEPTH];
    logic [PS2_FIFO_ADDR_BITS-1:0]  write_ptr;
    logic [PS2_FIFO_ADDR_BITS-1:0]  read_ptr;
    logic [PS2_FIFO_ADDR_BITS:0]    count;
    logic                           full;
    logic                           do_push;
    logic                           do_pop;

    assign empty = (count == '0);
    assign full  = (count == (PS2_FIFO_ADDR_BITS + 1)'(PS2_FIFO_DEPTH));

    // Bytes arriving while full are lost
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[write_ptr] <= push_data;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
        end else begin
            if (do_push) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (do_pop) begin
                read_ptr <= read_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (do_push && !do_pop) begin
            count <= count + 1'b1;
        end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
        end
    end

    // Oldest entry is always on the output
    assign pop_data = mem[read_ptr];

endmodule

// ==== verilog/scancode_decoder.sv ====
// Scancode set 2 decoder; drains the byte queue and emits key events with prefix flags
`timescale 1ns/10ps

module scancode_decoder (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [ps2_pkg::PS2_DATA_BITS-1:0]  fifo_data,
    input  logic                               fifo_empty,
    output logic                               fifo_pop,
    output logic                               key_valid,
    output logic [ps2_pkg::PS2_DATA_BITS-1:0]  key_code,
    output logic                               key_extended,
    output logic                               key_released
);
    import ps2_pkg::*;

    logic [PS2_DATA_BITS-1:0]  held_byte;
    logic                      held_valid;
    logic                      pending_extended;
    logic                      pending_released;

    // One byte in flight at a time, so events are never back to back
    assign fifo_pop = ~fifo_empty & ~held_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= fifo_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_pop) begin
            held_byte <= fifo_data;
        end
    end

    // Prefixes only arm flags; a code byte consumes them
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending_extended <= 1'b0;
            pending_released <= 1'b0;
        end else if (held_valid) begin
            if (held_byte == PS2_PREFIX_EXTENDED) begin
                pending_extended <= 1'b1;
            end else if (held_byte == PS2_PREFIX_RELEASE) begin
                pending_released <= 1'b1;
            end else begin
                pending_extended <= 1'b0;
                pending_released <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            key_valid    <= 1'b0;
            key_extended <= 1'b0;
            key_released <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (held_valid && held_byte != PS2_PREFIX_EXTENDED
                    && held_byte != PS2_PREFIX_RELEASE) begin
                key_valid    <= 1'b1;
                key_extended <= pending_extended;
                key_released <= pending_released;
            end
        end
    end

    // Code stays with its flags until the next event
    always_ff @(posedge clock) begin
        if (held_valid && held_byte != PS2_PREFIX_EXTENDED
                && held_byte != PS2_PREFIX_RELEASE) begin
            key_code <= held_byte;
        end
    end

endmodule

// ==== verilog/ps2_keyboard.sv ====
// PS/2 keyboard receiver top level; frame receiver feeding a byte queue and scancode decoder
`timescale 1ns/10ps

module ps2_keyboard (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               peripheral_clock,
    input  logic                               device_clock,
    input  logic                               device_data,
    output logic                               key_valid,
    output logic [ps2_pkg::PS2_DATA_BITS-1:0]  key_code,
    output logic                               key_extended,
    output logic                               key_released,
    output logic                               frame_error
);
    import ps2_pkg::*;

    logic [PS2_DATA_BITS-1:0]  byte_data;
    logic                      byte_strobe;
    logic [PS2_DATA_BITS-1:0]  fifo_data;
    logic                      fifo_empty;
    logic                      fifo_pop;

    ps2_shift_register ps2_shift_register_i (
        .clock            (clock),
        .reset            (reset),
        .peripheral_clock (peripheral_clock),
        .device_clock     (device_clock),
        .device_data      (device_data),
        .byte_data        (byte_data),
        .byte_strobe      (byte_strobe),
        .frame_error      (frame_error)
    );

    ps2_fifo ps2_fifo_i (
        .clock     (clock),
        .reset     (reset),
        .push      (byte_strobe),
        .push_data (byte_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty)
    );

    scancode_decoder scancode_decoder_i (
        .clock        (clock),
        .reset        (reset),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_extended (key_extended),
        .key_released (key_released)
    );

endmodule

// ==== bench/ps2_keyboard_sva.sv ====
// Concurrent protocol checks on the PS/2 keyboard receiver, bound into the top level
`timescale 1ns/10ps

module ps2_keyboard_sva (
    input logic clock,
    input logic reset,
    input logic byte_strobe,
    input logic fifo_pop,
    input logic fifo_empty,
    input logic key_valid,
    input logic frame_error
);
    logic strobe_seen;

    // Set by the first good byte after reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            strobe_seen <= 1'b0;
        end else if (byte_strobe) begin
            strobe_seen <= 1'b1;
        end
    end

    event_error_apart: assert property (@(posedge clock) disable iff (reset)
        !($rose(key_valid) && $rose(frame_error)))
        else $error("key_valid and frame_error rose in the same cycle");

    pop_only_when_filled: assert property (@(posedge clock) disable iff (reset)
        !(fifo_pop && fifo_empty))
        else $error("fifo_pop high while fifo_empty is high");

    event_single_cycle: assert property (@(posedge clock) disable iff (reset)
        key_valid |=> !key_valid)
        else $error("key_valid high for two cycles in a row");

    no_event_before_byte: assert property (@(posedge clock) disable iff (reset)
        !strobe_seen |-> !key_valid)
        else $error("key_valid raised before any byte_strobe");

endmodule

bind ps2_keyboard ps2_keyboard_sva ps2_keyboard_sva_i (
    .clock       (clock),
    .reset       (reset),
    .byte_strobe (byte_strobe),
    .fifo_pop    (fifo_pop),
    .fifo_empty  (fifo_empty),
    .key_valid   (key_valid),
    .frame_error (frame_error)
);

// ==== bench/ps2_keyboard_tb.sv ====
// Directed testbench for the PS/2 keyboard receiver; sends device frames and checks key events
`timescale 1ns/10ps

module ps2_keyboard_tb;
    import ps2_pkg::*;

    // Timebase toggles every two clock cycles
    localparam int TICK_CYCLES = 4;
    localparam int EVENT_TIMEOUT = 200;
    localparam int ERROR_TIMEOUT = 200;
    localparam int SETTLE_CYCLES = 40;
    localparam int SILENCE_MIN = (int'(PS2_TIMEOUT_TICKS) - 1) * TICK_CYCLES;
    localparam int SILENCE_BOUND = int'(PS2_TIMEOUT_TICKS) * TICK_CYCLES + 20;

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      peripheral_clock = 1'b0;
    logic                      device_clock;
    logic                      device_data;
    logic                      key_valid;
    logic [PS2_DATA_BITS-1:0]  key_code;
    logic                      key_extended;
    logic                      key_released;
    logic                      frame_error;

    int seed = 87895;
    int errors = 0;
    int tests_run = 0;
    int error_pulses = 0;
    int next_event = 0;

    logic [PS2_DATA_BITS-1:0]  event_codes[$];
    logic                      event_extended[$];
    logic                      event_released[$];

    ps2_keyboard ps2_keyboard_i (
        .clock            (clock),
        .reset            (reset),
        .peripheral_clock (peripheral_clock),
        .device_clock     (device_clock),
        .device_data      (device_data),
        .key_valid        (key_valid),
        .key_code         (key_code),
        .key_extended     (key_extended),
        .key_released     (key_released),
        .frame_error      (frame_error)
    );

    always #10 clock = ~clock;

    always begin
        repeat (2) @(negedge clock);
        peripheral_clock = ~peripheral_clock;
    end

    // Outputs settle after the rising edge, sampled on the falling one
    always @(negedge clock) begin
        if (key_valid) begin
            event_codes.push_back(key_code);
            event_extended.push_back(key_extended);
            event_released.push_back(key_released);
        end
        if (frame_error) begin
            error_pulses++;
        end
    end

    function automatic logic [PS2_DATA_BITS-1:0] random_code();
        int value;
        logic [PS2_DATA_BITS-1:0] code;
        code = PS2_PREFIX_EXTENDED;
        while (code == PS2_PREFIX_EXTENDED || code == PS2_PREFIX_RELEASE) begin
            value = $random(seed);
            code = value[7:0];
        end
        return code;
    endfunction

    // Start, data LSB first, odd parity, stop; data_bits below 8 cuts the frame short
    task automatic send_frame(input logic [PS2_DATA_BITS-1:0] data, input bit bad_parity,
                              input bit low_stop, input int data_bits);
        logic [10:0] frame;
        int bit_total;
        frame[0] = 1'b0;
        frame[8:1] = data;
        frame[9] = ~(^data) ^ bad_parity;
        frame[10] = ~low_stop;
        bit_total = (data_bits < 8) ? data_bits + 1 : 11;
        @(negedge clock);
        for (int i = 0; i < bit_total; i++) begin
            device_data = frame[0];
            frame = {1'b1, frame[10:1]};
            repeat (10) @(negedge clock);
            device_clock = 1'b0;
            repeat (10) @(negedge clock);
            device_clock = 1'b1;
        end
        device_data = 1'b1;
    endtask

    task automatic expect_event(input logic [PS2_DATA_BITS-1:0] code, input logic extended,
                                input logic released);
        int cycles;
        cycles = 0;
        while (event_codes.size() <= next_event && cycles < EVENT_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        assert (event_codes.size() > next_event) else begin
            $display("Timed out waiting for a key event with code %h", code);
            errors++;
        end
        if (event_codes.size() > next_event) begin
            assert (event_codes[next_event] == code) else begin
                $display("Fail at %0t: key_code = %h, expected %h", $time,
                         event_codes[next_event], code);
                errors++;
            end
            assert (event_extended[next_event] == extended) else begin
                $display("Fail at %0t: key_extended = %b, expected %b", $time,
                         event_extended[next_event], extended);
                errors++;
            end
            assert (event_released[next_event] == released) else begin
                $display("Fail at %0t: key_released = %b, expected %b", $time,
                         event_released[next_event], released);
                errors++;
            end
            next_event++;
        end
    endtask

    task automatic wait_for_frame_error(input int start_pulses, input int limit,
                                        output int cycles);
        cycles = 0;
        while (error_pulses == start_pulses && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        assert (error_pulses != start_pulses) else begin
            $display("No frame_error pulse arrived within %0d cycles", limit);
            errors++;
        end
    endtask

    // Exactly one error pulse and no key event for the rejected frame
    task automatic check_rejected(input int start_pulses);
        repeat (SETTLE_CYCLES) @(posedge clock);
        assert (error_pulses == start_pulses + 1) else begin
            $display("Fail at %0t: frame_error pulses = %0d, expected %0d", $time,
                     error_pulses - start_pulses, 1);
            errors++;
        end
        assert (event_codes.size() == next_event) else begin
            $display("Fail at %0t: key_valid events = %0d, expected %0d", $time,
                     event_codes.size() - next_event, 0);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic plain_code_test();
        int start_errors;
        logic [PS2_DATA_BITS-1:0] code;
        start_errors = errors;
        for (int i = 0; i < 20; i++) begin
            code = random_code();
            send_frame(code, 1'b0, 1'b0, 8);
            expect_event(code, 1'b0, 1'b0);
        end
        report_test("plain make codes", start_errors);
    endtask

    task automatic prefix_test();
        int start_errors;
        start_errors = errors;
        send_frame(PS2_PREFIX_RELEASE, 1'b0, 1'b0, 8);
        send_frame(8'h1C, 1'b0, 1'b0, 8);
        expect_event(8'h1C, 1'b0, 1'b1);
        send_frame(8'h1C, 1'b0, 1'b0, 8);
        expect_event(8'h1C, 1'b0, 1'b0);
        send_frame(PS2_PREFIX_EXTENDED, 1'b0, 1'b0, 8);
        send_frame(8'h75, 1'b0, 1'b0, 8);
        expect_event(8'h75, 1'b1, 1'b0);
        send_frame(8'h32, 1'b0, 1'b0, 8);
        expect_event(8'h32, 1'b0, 1'b0);
        // Extended key release carries both flags
        send_frame(PS2_PREFIX_EXTENDED, 1'b0, 1'b0, 8);
        send_frame(PS2_PREFIX_RELEASE, 1'b0, 1'b0, 8);
        send_frame(8'h75, 1'b0, 1'b0, 8);
        expect_event(8'h75, 1'b1, 1'b1);
        send_frame(8'h1C, 1'b0, 1'b0, 8);
        expect_event(8'h1C, 1'b0, 1'b0);
        report_test("prefix decoding", start_errors);
    endtask

    task automatic parity_error_test();
        int start_errors;
        int start_pulses;
        int cycles;
        logic [PS2_DATA_BITS-1:0] code;
        start_errors = errors;
        start_pulses = error_pulses;
        send_frame(random_code(), 1'b1, 1'b0, 8);
        wait_for_frame_error(start_pulses, ERROR_TIMEOUT, cycles);
        check_rejected(start_pulses);
        code = random_code();
        send_frame(code, 1'b0, 1'b0, 8);
        expect_event(code, 1'b0, 1'b0);
        report_test("parity error", start_errors);
    endtask

    task automatic stop_bit_error_test();
        int start_errors;
        int start_pulses;
        int cycles;
        start_errors = errors;
        start_pulses = error_pulses;
        send_frame(random_code(), 1'b0, 1'b1, 8);
        wait_for_frame_error(start_pulses, ERROR_TIMEOUT, cycles);
        check_rejected(start_pulses);
        report_test("stop bit error", start_errors);
    endtask

    task automatic silence_timeout_test();
        int start_errors;
        int start_pulses;
        int cycles;
        logic [PS2_DATA_BITS-1:0] code;
        start_errors = errors;
        start_pulses = error_pulses;
        // Start bit and four data bits, then both lines idle high
        send_frame(random_code(), 1'b0, 1'b0, 4);
        wait_for_frame_error(start_pulses, SILENCE_BOUND, cycles);
        assert (cycles >= SILENCE_MIN) else begin
            $display("Fail at %0t: frame_error latency = %0d cycles, expected at least %0d",
                     $time, cycles, SILENCE_MIN);
            errors++;
        end
        check_rejected(start_pulses);
        code = random_code();
        send_frame(code, 1'b0, 1'b0, 8);
        expect_event(code, 1'b0, 1'b0);
        report_test("silence timeout", start_errors);
    endtask

    task automatic back_to_back_test();
        int start_errors;
        logic [PS2_DATA_BITS-1:0] codes[$];
        start_errors = errors;
        for (int i = 0; i < 8; i++) begin
            codes.push_back(random_code());
            send_frame(codes[i], 1'b0, 1'b0, 8);
        end
        for (int i = 0; i < 8; i++) begin
            expect_event(codes[i], 1'b0, 1'b0);
        end
        report_test("back-to-back bytes", start_errors);
    endtask

    initial begin
        reset = 1'b1;
        device_clock = 1'b1;
        device_data = 1'b1;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        repeat (5) @(negedge clock);

        plain_code_test();
        prefix_test();
        parity_error_test();
        stop_bit_error_test();
        silence_timeout_test();
        back_to_back_test();

        $display("Tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== ps2_keyboard.f ====
verilog/ps2_pkg.sv
verilog/ps2_shift_register.sv
verilog/ps2_fifo.sv
verilog/scancode_decoder.sv
verilog/ps2_keyboard.sv
bench/ps2_keyboard_sva.sv
bench/ps2_keyboard_tb.sv

// ==== Makefile ====
# Verilator build and run of the PS/2 keyboard receiver testbench

SOURCES := $(wildcard verilog/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vps2_keyboard_tb: ps2_keyboard.f $(SOURCES)
	verilator --binary --timing --assert -f ps2_keyboard.f \
		--top-module ps2_keyboard_tb -Mdir obj_dir

run: obj_dir/Vps2_keyboard_tb
	@out="$$(./obj_dir/Vps2_keyboard_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
